/* mbCore.f */
mbCorePkg.sv
mbDecode.sv
mbExecute.sv
mbRegFile.sv
mbCore.sv
mbCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the mbCore testbench with Verilator
cd "$(dirname "$0")" \
   && verilator --binary --assert -f mbCore.f --top-module mbCoreTb -o mbCoreSim \
   && ./obj_dir/mbCoreSim \
   || { echo "mbCore simulation did not pass"; exit 1; }

/* mbCoreTb.sv */
// MicroBlaze datapath testbench
module mbCoreTb
   import mbCorePkg::*;
();

   // Expected store on the data bus
   typedef struct packed {
      word_t    addr;
      byteSel_t sel;
      word_t    data;
   } storeRec_t;

   logic       gclk;
   logic       grst;
   logic       ena;
   logic       instrValid;
   word_t      instr;
   word_t      dataAddr;
   byteSel_t   dataSel;
   logic       dataRead;
   logic       dataWrite;
   word_t      dataOut;
   word_t      dataIn;
   // Memory seen by the DUT and its copy kept in program order
   logic [7:0] memBytes [256];
   logic [7:0] shadowMem [256];
   word_t      shadowReg [32];
   logic [7:0] memBase;
   // Pending stores, head mirrored into plain variables
   storeRec_t  expQ [$];
   storeRec_t  expHead;
   logic       expValid;
   // A store was checked at the last rising edge
   logic       storeSeen;
   logic       stallMode;
   integer     seed;
   string      testName;

   mbCore UUT (.*);

   always #20 gclk = ~gclk;

   // Big-endian word read, answered in the same cycle
   // Read data only while the DUT reads
   assign memBase = {dataAddr[7:2], 2'b00};
   assign dataIn  = dataRead ? {memBytes[memBase], memBytes[memBase + 8'd1],
                                memBytes[memBase + 8'd2], memBytes[memBase + 8'd3]} : '0;

   // Fill pattern during reset, stores on enabled edges
   always @(posedge gclk) begin
      storeSeen <= !grst && ena && dataWrite;
      for (int i = 0; i < 256; i++) begin
         if (grst) memBytes[i] <= 8'(i * 29 + 17);
      end
      for (int o = 0; o < 4; o++) begin
         if (!grst && ena && dataWrite && dataSel[3 - o])
            memBytes[memBase + 8'(o)] <= dataOut[31 - 8 * o -: 8];
      end
   end

   // Every enabled store must match the oldest expected record
   storeCheck: assert property (@(posedge gclk) disable iff (grst)
      (ena && dataWrite) |-> (expValid && dataAddr == expHead.addr &&
         dataSel == expHead.sel && dataOut == expHead.data))
      else reportStore($sampled(dataAddr), $sampled(dataSel), $sampled(dataOut));

   // Bus leaves reset idle with cleared store data
   resetIdle: assert property (@(posedge gclk)
      grst |=> (!dataRead && !dataWrite && dataOut == '0))
      else idleMismatch($sampled(dataRead), $sampled(dataWrite), $sampled(dataOut));

   task automatic failRun(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic reportStore(input word_t addr, input byteSel_t sel, input word_t data);
      if (!expValid) begin
         failRun("a store reached the data bus with none expected");
      end else begin
         $display("CHECK FAILED %s expected addr %h sel %h data %h actual addr %h sel %h data %h",
            testName, expHead.addr, expHead.sel, expHead.data, addr, sel, data);
         failRun("store does not match the reference model");
      end
   endtask

   task automatic idleMismatch(input logic rdBit, input logic wrBit, input word_t data);
      $display("CHECK FAILED %s expected read 0 write 0 data %h actual read %b write %b data %h",
         testName, 32'h0, rdBit, wrBit, data);
      failRun("data bus not idle after reset");
   endtask

   task automatic refreshHead();
      expValid = (expQ.size() != 0);
      if (expValid) expHead = expQ[0];
   endtask

   // Falling edge, retire the store checked before it, then drive
   task automatic stepCycle(input logic en, input logic valid, input word_t word);
      @(negedge gclk);
      if (storeSeen) begin
         void'(expQ.pop_front());
         refreshHead();
      end
      ena        = en;
      instrValid = valid;
      instr      = word;
   endtask

   function automatic word_t rrInstr(input opcode_t op, input regAddr_t rd,
                                     input regAddr_t ra, input regAddr_t rb);
      return {op, rd, ra, rb, 11'd0};
   endfunction

   function automatic word_t immInstr(input opcode_t op, input regAddr_t rd,
                                      input regAddr_t ra, input logic [15:0] imm);
      return {op, rd, ra, imm};
   endfunction

   // Mostly legal ops, some raw words that may decode to no-ops
   function automatic word_t randomInstr();
      word_t w;
      int    pick;
      w    = $random(seed);
      pick = $unsigned($random(seed)) % 10;
      if (pick < 5) w = {opcode_t'(pick), w[25:11], 11'd0};
      else if (pick < 7) w[31:26] = opAddi;
      else if (pick == 7) w[31:26] = opLbu + opcode_t'($unsigned($random(seed)) % 3);
      else if (pick == 8) w[31:26] = opSb + opcode_t'($unsigned($random(seed)) % 3);
      return w;
   endfunction

   // Reference rules applied in program order
   task automatic modelStep(input word_t word);
      opcode_t    op;
      regAddr_t   rd;
      word_t      a;
      word_t      b;
      word_t      imm;
      word_t      addr;
      word_t      val;
      byteSel_t   sel;
      logic [7:0] base;
      logic       writes;
      int         n;
      storeRec_t  rec;
      op   = word[31:26];
      rd   = word[25:21];
      a    = shadowReg[word[20:16]];
      b    = shadowReg[word[15:11]];
      imm  = {{16{word[15]}}, word[15:0]};
      // Width in bytes, address aligned down to it
      n    = (op[1:0] == 2'd0) ? 1 : (op[1:0] == 2'd1) ? 2 : 4;
      addr = (a + imm) & ~word_t'(n - 1);
      base = {addr[7:2], 2'b00};
      // Lane o lies inside the access, offset 0 on bit 3
      for (int o = 0; o < 4; o++) begin
         sel[3 - o] = (o >= int'(addr[1:0])) && (o < int'(addr[1:0]) + n);
      end
      val    = '0;
      writes = 1'b1;
      case (op)
         opAdd:  val = a + b;
         opSub:  val = a - b;
         opOr:   val = a | b;
         opAnd:  val = a & b;
         opXor:  val = a ^ b;
         opAddi: val = a + imm;
         opLbu, opLhu, opLw: begin
            // Selected bytes in address order, zero-extended
            for (int o = 0; o < 4; o++) begin
               if (sel[3 - o]) val = {val[23:0], shadowMem[base + 8'(o)]};
            end
         end
         opSb, opSh, opSw: begin
            for (int o = 0; o < 4; o++) begin
               // Each lane repeats the low bytes of the access size
               rec.data[31 - 8 * o -: 8] = shadowReg[rd][8 * (n - 1 - o % n) +: 8];
               if (sel[3 - o]) shadowMem[base + 8'(o)] = rec.data[31 - 8 * o -: 8];
            end
            rec.addr = addr;
            rec.sel  = sel;
            expQ.push_back(rec);
            refreshHead();
            writes = 1'b0;
         end
         default: writes = 1'b0;
      endcase
      if (writes && rd != '0) shadowReg[rd] = val;
   endtask

   // Optional ena-low gap with junk on the strobe, then the instruction
   task automatic issue(input word_t word);
      int gap;
      gap = stallMode ? $unsigned($random(seed)) % 3 : 0;
      repeat (gap) stepCycle(1'b0, 1'b1, $random(seed));
      stepCycle(1'b1, 1'b1, word);
      modelStep(word);
   endtask

   // Idle until every expected store has gone by
   task automatic drain();
      int waited;
      waited = 0;
      while (expQ.size() != 0) begin
         if (waited == 200) begin
            failRun("timeout waiting for expected stores");
         end else begin
            stepCycle(1'b1, 1'b0, '0);
            waited++;
         end
      end
   endtask

   initial begin
      seed       = 32'haf4e_ee0b;
      gclk       = 1'b0;
      grst       = 1'b1;
      ena        = 1'b0;
      instrValid = 1'b0;
      instr      = '0;
      stallMode  = 1'b0;
      testName   = "setup";
      for (int i = 0; i < 256; i++) shadowMem[i] = 8'(i * 29 + 17);
      for (int r = 0; r < 32; r++) shadowReg[r] = '0;
      refreshHead();
      repeat (10) @(posedge gclk);
      @(negedge gclk);
      grst = 1'b0;
      // Known value in every register, each stored right after its write
      for (int r = 1; r < 32; r++) begin
         issue(immInstr(opAddi, regAddr_t'(r), 5'd0, 16'($random(seed))));
         issue(immInstr(opSw, regAddr_t'(r), 5'd0, 16'(r * 4)));
      end
      drain();
      testName = "alu";
      for (int k = 0; k < 5; k++) begin
         issue(rrInstr(opcode_t'(k), 5'd20, regAddr_t'(k + 1), regAddr_t'(k + 7)));
         issue(immInstr(opSw, 5'd20, 5'd0, 16'(8'h80 + 4 * k)));
      end
      drain();
      testName = "storeSize";
      issue(immInstr(opAddi, 5'd3, 5'd0, 16'h9a5c));
      for (int o = 0; o < 4; o++) issue(immInstr(opSb, 5'd3, 5'd0, 16'(8'hc0 + o)));
      issue(immInstr(opSh, 5'd3, 5'd0, 16'h00c4));
      issue(immInstr(opSh, 5'd3, 5'd0, 16'h00c6));
      drain();
      // Loads from the untouched fill region, each stored at once
      testName = "loadSize";
      for (int o = 0; o < 4; o++) begin
         issue(immInstr(opLbu, 5'd4, 5'd0, 16'(8'ha0 + o)));
         issue(immInstr(opSw, 5'd4, 5'd0, 16'(8'hd0 + 4 * o)));
         issue(immInstr(opLhu, 5'd5, 5'd0, 16'(8'ha4 + (o & 2))));
         issue(immInstr(opSw, 5'd5, 5'd0, 16'(8'he0 + 4 * o)));
      end
      issue(immInstr(opLw, 5'd6, 5'd0, 16'h00a8));
      issue(immInstr(opSw, 5'd6, 5'd0, 16'h00f0));
      drain();
      testName = "hazards";
      issue(rrInstr(opAdd, 5'd7, 5'd1, 5'd2));
      issue(rrInstr(opSub, 5'd8, 5'd7, 5'd1));
      issue(rrInstr(opAdd, 5'd9, 5'd8, 5'd7));
      issue(immInstr(opSw, 5'd9, 5'd0, 16'h00f4));
      issue(immInstr(opLw, 5'd10, 5'd0, 16'h00a8));
      issue(rrInstr(opOr, 5'd11, 5'd10, 5'd3));
      issue(immInstr(opSw, 5'd11, 5'd0, 16'h00f8));
      drain();
      // Stall gaps stay on from here
      testName  = "r0Stall";
      stallMode = 1'b1;
      issue(immInstr(opAddi, 5'd0, 5'd0, 16'h1234));
      issue(immInstr(opSw, 5'd0, 5'd0, 16'h00fc));
      issue(rrInstr(opAdd, 5'd0, 5'd1, 5'd2));
      issue(rrInstr(opAdd, 5'd12, 5'd0, 5'd0));
      issue(immInstr(opSw, 5'd12, 5'd0, 16'h00fc));
      drain();
      testName = "random";
      for (int k = 0; k < 200; k++) begin
         issue(randomInstr());
         if (k % 4 == 3)
            issue(immInstr(opSw, regAddr_t'($random(seed)), 5'd0, 16'(8'h40 + 4 * (k % 16))));
      end
      drain();
      if (expQ.size() == 0) begin
         $display("test passed");
         $finish;
      end else begin
         failRun("stores left unchecked at the end of the run");
      end
   end

endmodule

/* mbCore.sv */
// MicroBlaze integer datapath top
module mbCore
   import mbCorePkg::*;
(
   input  logic     gclk,
   input  logic     grst,
   // Global stall, low holds the whole pipe
   input  logic     ena,
   // Instruction strobe and word
   input  logic     instrValid,
   input  word_t    instr,
   // Data bus
   output word_t    dataAddr,
   output byteSel_t dataSel,
   output logic     dataRead,
   output logic     dataWrite,
   output word_t    dataOut,
   input  word_t    dataIn
);

   // Stage buses
   decodeBus_t dec;
   memBus_t    mem;
   // Register reads
   word_t      regA;
   word_t      regB;
   // Writeback bypass
   logic       wbEn;
   word_t      wbData;

   // Decode
   mbDecode uDecode (
      .gclk       (gclk),
      .grst       (grst),
      .ena        (ena),
      .instrValid (instrValid),
      .instr      (instr),
      .dec        (dec)
   );

   // Execute, bypassed from writeback
   mbExecute uExecute (
      .gclk   (gclk),
      .grst   (grst),
      .ena    (ena),
      .dec    (dec),
      .regA   (regA),
      .regB   (regB),
      .wbEn   (wbEn),
      .wbRw   (mem.rw),
      .wbData (wbData),
      .mem    (mem)
   );

   // Register file, sizers and writeback
   mbRegFile uRegFile (
      .gclk    (gclk),
      .grst    (grst),
      .ena     (ena),
      .dec     (dec),
      .mem     (mem),
      .dataIn  (dataIn),
      .regA    (regA),
      .regB    (regB),
      .dataOut (dataOut),
      .wbEn    (wbEn),
      .wbData  (wbData)
   );

   // Memory side of the execute bus
   assign dataAddr  = mem.addr;
   assign dataSel   = mem.sel;
   assign dataRead  = mem.read;
   assign dataWrite = mem.write;

endmodule

/* mbRegFile.sv */
// Register file with load and store sizing
module mbRegFile
   import mbCorePkg::*;
(
   input  logic       gclk,
   input  logic       grst,
   input  logic       ena,
   input  decodeBus_t dec,
   input  memBus_t    mem,
   input  word_t      dataIn,
   output word_t      regA,
   output word_t      regB,
   output word_t      dataOut,
   output logic       wbEn,
   output word_t      wbData
);

   // General purpose registers, r0 is never written
   word_t regs [32];
   // Third read port, store source
   word_t regD;
   // Store source after forwarding
   word_t storeSrc;
   // Replicated store word
   word_t storeData;
   // Zero-extended load data
   word_t loadData;

   // Combinational reads, r0 forced to zero
   assign regA = (dec.ra == '0) ? '0 : regs[dec.ra];
   assign regB = (dec.rb == '0) ? '0 : regs[dec.rb];
   assign regD = (dec.rd == '0) ? '0 : regs[dec.rd];

   // Load sizer
   // Picks the selected lanes of dataIn and zero-extends them
   always_comb begin
      loadData = '0;
      case (mem.size)
         sizeByte: begin
            case (mem.sel)
               4'h8:    loadData[7:0] = dataIn[31:24];
               4'h4:    loadData[7:0] = dataIn[23:16];
               4'h2:    loadData[7:0] = dataIn[15:8];
               default: loadData[7:0] = dataIn[7:0];
            endcase
         end
         sizeHalf: begin
            // Upper half at offset 0
            loadData[15:0] = mem.sel[3] ? dataIn[31:16] : dataIn[15:0];
         end
         default: begin
            loadData = dataIn;
         end
      endcase
   end

   // Writeback source mux
   always_comb begin
      case (mem.wbSrc)
         wbAlu:   wbData = mem.result;
         wbLoad:  wbData = loadData;
         default: wbData = mem.result;
      endcase
   end

   // Write only for a real source, a nonzero target and an enabled cycle
   assign wbEn = ena && (mem.wbSrc != wbNone) && (mem.rw != '0);

   // Register write at the end of the writeback cycle
   always_ff @(posedge gclk) begin
      if (wbEn) begin
         regs[mem.rw] <= wbData;
      end
   end

   // Store data forwarding
   // The instruction in writeback has not reached the array yet
   assign storeSrc = (wbEn && mem.rw == dec.rd) ? wbData : regD;

   // Store sizer
   // Low byte or halfword copied to every lane of its size
   always_comb begin
      case (dec.opcode[1:0])
         sizeByte: storeData = {4{storeSrc[7:0]}};
         sizeHalf: storeData = {2{storeSrc[15:0]}};
         default:  storeData = storeSrc;
      endcase
   end

   // Registered on the same edge as the memory bus
   always_ff @(posedge gclk) begin
      if (grst) begin
         dataOut <= '0;
      end else if (ena && dec.isStore) begin
         dataOut <= storeData;
      end
   end

   // A load in writeback carries a read and lanes that fit its size
   loadSelLegal: assert property (@(posedge gclk) disable iff (grst)
      (mem.wbSrc == wbLoad) |->
         (mem.read &&
          ((mem.size == sizeByte && mem.sel inside {4'h8, 4'h4, 4'h2, 4'h1}) ||
           (mem.size == sizeHalf && mem.sel inside {4'hc, 4'h3}) ||
           (mem.size == sizeWord && mem.sel == 4'hf))))
      else $error("load in writeback with illegal byte select");

endmodule

/* mbExecute.sv */
// Execute stage and address generation
module mbExecute
   import mbCorePkg::*;
(
   input  logic       gclk,
   input  logic       grst,
   input  logic       ena,
   input  decodeBus_t dec,
   input  word_t      regA,
   input  word_t      regB,
   input  logic       wbEn,
   input  regAddr_t   wbRw,
   input  word_t      wbData,
   output memBus_t    mem
);

   // Operands after bypass
   word_t      opA;
   word_t      regBFwd;
   word_t      opB;
   // ALU result, also the raw memory address
   word_t      aluOut;
   // Aligned address and lane select
   word_t      addr;
   byteSel_t   sel;
   logic [1:0] size;
   memBus_t    memNext;

   // Bypass from the instruction now in writeback
   // wbEn already excludes r0 and disabled cycles
   assign opA     = (wbEn && wbRw == dec.ra) ? wbData : regA;
   assign regBFwd = (wbEn && wbRw == dec.rb) ? wbData : regB;
   // Memory ops and ADDI take the immediate
   assign opB     = dec.useImm ? dec.imm : regBFwd;

   // ALU
   always_comb begin
      case (dec.opcode)
         // SUB is ra minus rb
         opSub:   aluOut = opA - opB;
         opOr:    aluOut = opA | opB;
         opAnd:   aluOut = opA & opB;
         opXor:   aluOut = opA ^ opB;
         // ADD, ADDI and every memory address
         default: aluOut = opA + opB;
      endcase
   end

   // Size comes straight from the opcode low bits
   assign size = dec.opcode[1:0];

   // Big-endian lane select, address forced aligned to the size
   always_comb begin
      addr = aluOut;
      sel  = '0;
      if (dec.isLoad || dec.isStore) begin
         case (size)
            sizeByte: begin
               // Offset 0 is the top lane
               sel = byteSel_t'(4'b1000 >> aluOut[1:0]);
            end
            sizeHalf: begin
               addr[0] = 1'b0;
               sel     = aluOut[1] ? 4'b0011 : 4'b1100;
            end
            default: begin
               addr[1:0] = 2'b00;
               sel       = 4'b1111;
            end
         endcase
      end
   end

   // Next memory and writeback bus
   always_comb begin
      memNext.addr   = addr;
      memNext.sel    = sel;
      memNext.read   = dec.isLoad;
      memNext.write  = dec.isStore;
      memNext.size   = size;
      memNext.rw     = dec.rd;
      memNext.wbSrc  = dec.wbSrc;
      memNext.result = aluOut;
   end

   // Stage register, control cleared at reset
   always_ff @(posedge gclk) begin
      if (grst) begin
         mem.read  <= 1'b0;
         mem.write <= 1'b0;
         mem.rw    <= '0;
         mem.wbSrc <= wbNone;
      end else if (ena) begin
         mem <= memNext;
      end
   end

   // Never a read and a write in the same cycle
   readWriteExclusive: assert property (@(posedge gclk) disable iff (grst)
      !(mem.read && mem.write))
      else $error("memory bus reads and writes at once");

   // Only the seven legal lane patterns reach the bus
   selLegal: assert property (@(posedge gclk) disable iff (grst)
      (mem.read || mem.write) |->
         (mem.sel inside {4'h8, 4'h4, 4'h2, 4'h1, 4'hc, 4'h3, 4'hf}))
      else $error("illegal byte select on memory bus");

endmodule

/* mbDecode.sv */
// Instruction decode stage
module mbDecode
   import mbCorePkg::*;
(
   input  logic       gclk,
   input  logic       grst,
   input  logic       ena,
   input  logic       instrValid,
   input  word_t      instr,
   output decodeBus_t dec
);

   // Raw instruction fields
   opcode_t     opcode;
   regAddr_t    rd;
   regAddr_t    ra;
   regAddr_t    rb;
   logic [15:0] imm16;
   // Decoded but not yet registered
   decodeBus_t  decNext;

   // Field split
   assign opcode = opcode_t'(instr[opFieldHi:opFieldLo]);
   assign rd     = regAddr_t'(instr[rdFieldHi:rdFieldLo]);
   assign ra     = regAddr_t'(instr[raFieldHi:raFieldLo]);
   assign rb     = regAddr_t'(instr[rbFieldHi:rbFieldLo]);
   assign imm16  = instr[immFieldHi:immFieldLo];

   // Opcode classes
   always_comb begin
      decNext         = decNop;
      decNext.opcode  = opcode;
      decNext.rd      = rd;
      decNext.ra      = ra;
      decNext.rb      = rb;
      // Sign extension of the 16-bit immediate
      decNext.imm     = {{16{imm16[15]}}, imm16};
      case (opcode)
         // Register-register ALU
         opAdd, opSub, opOr, opAnd, opXor: begin
            decNext.useImm = 1'b0;
            decNext.wbSrc  = wbAlu;
         end
         // ALU with immediate
         opAddi: begin
            decNext.useImm = 1'b1;
            decNext.wbSrc  = wbAlu;
         end
         // Loads write the sized memory data
         opLbu, opLhu, opLw: begin
            decNext.useImm = 1'b1;
            decNext.isLoad = 1'b1;
            decNext.wbSrc  = wbLoad;
         end
         // Stores never write a register
         opSb, opSh, opSw: begin
            decNext.useImm  = 1'b1;
            decNext.isStore = 1'b1;
            decNext.wbSrc   = wbNone;
         end
         // Anything else passes as a no-op
         default: begin
            decNext.useImm = 1'b0;
            decNext.wbSrc  = wbNone;
         end
      endcase
   end

   // Decode register, a bubble when nothing is taken
   always_ff @(posedge gclk) begin
      if (grst) begin
         dec <= decNop;
      end else if (ena) begin
         if (instrValid) begin
            dec <= decNext;
         end else begin
            dec <= decNop;
         end
      end
   end

   // Load and store classes never overlap
   loadStoreExclusive: assert property (@(posedge gclk) disable iff (grst)
      !(dec.isLoad && dec.isStore))
      else $error("decode bus flags both load and store");

endmodule

/* mbCorePkg.sv */
// MicroBlaze datapath definitions
package mbCorePkg;

   // Data word and register index
   typedef logic [31:0] word_t;
   typedef logic [4:0]  regAddr_t;
   // Byte lanes, bit 3 is address offset 0 on this big-endian bus
   typedef logic [3:0]  byteSel_t;
   // Primary opcode, low two bits give the access size for memory ops
   typedef logic [5:0]  opcode_t;
   typedef logic [1:0]  wbSrc_t;

   // Writeback sources
   localparam wbSrc_t wbAlu  = 2'd0;
   localparam wbSrc_t wbLoad = 2'd1;
   localparam wbSrc_t wbNone = 2'd3;

   // Access sizes
   localparam logic [1:0] sizeByte = 2'd0;
   localparam logic [1:0] sizeHalf = 2'd1;
   localparam logic [1:0] sizeWord = 2'd2;

   // Register-register ALU group
   localparam opcode_t opAdd  = 6'h00;
   localparam opcode_t opSub  = 6'h01;
   localparam opcode_t opOr   = 6'h02;
   localparam opcode_t opAnd  = 6'h03;
   localparam opcode_t opXor  = 6'h04;
   localparam opcode_t opAddi = 6'h08;
   // Zero-extending loads
   localparam opcode_t opLbu  = 6'h30;
   localparam opcode_t opLhu  = 6'h31;
   localparam opcode_t opLw   = 6'h32;
   // Stores
   localparam opcode_t opSb   = 6'h34;
   localparam opcode_t opSh   = 6'h35;
   localparam opcode_t opSw   = 6'h36;
   // Unused code, carried by pipeline bubbles
   localparam opcode_t opNop  = 6'h3f;

   // Instruction field positions
   localparam int opFieldHi  = 31;
   localparam int opFieldLo  = 26;
   localparam int rdFieldHi  = 25;
   localparam int rdFieldLo  = 21;
   localparam int raFieldHi  = 20;
   localparam int raFieldLo  = 16;
   localparam int rbFieldHi  = 15;
   localparam int rbFieldLo  = 11;
   localparam int immFieldHi = 15;
   localparam int immFieldLo = 0;

   // Decode stage output
   typedef struct packed {
      opcode_t  opcode;
      regAddr_t rd;
      regAddr_t ra;
      regAddr_t rb;
      word_t    imm;
      logic     useImm;
      logic     isLoad;
      logic     isStore;
      wbSrc_t   wbSrc;
   } decodeBus_t;

   // Execute stage output, also the writeback stage
   typedef struct packed {
      word_t      addr;
      byteSel_t   sel;
      logic       read;
      logic       write;
      logic [1:0] size;
      regAddr_t   rw;
      wbSrc_t     wbSrc;
      word_t      result;
   } memBus_t;

   // Bubble, no write and no memory access
   localparam decodeBus_t decNop = '{opcode: opNop, rd: '0, ra: '0, rb: '0, imm: '0,
      useImm: 1'b0, isLoad: 1'b0, isStore: 1'b0, wbSrc: wbNone};

endpackage
